//--- logic/noc_params.svh
// sizing of the spidergon network and the widths of the flit fields
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// nodes on the ring and width of a node id
`define NOC_NUM_NODES 8
`define NOC_NODE_W 3

// virtual channels per input port, vc field width, flits per vc
`define NOC_NUM_VCS 2
`define NOC_VC_W 1
`define NOC_VC_DEPTH 2

// payload left in a head flit after dest and src, and in a body or tail flit
`define NOC_HEAD_PAYLOAD_W 9
`define NOC_BODY_PAYLOAD_W 15

// anticlockwise, clockwise and across
`define NOC_NUM_DIRS 3

`endif

//--- logic/noc_pkg.sv
// flit, link, direction and port status types shared by the spidergon node
`default_nettype none
`include "noc_params.svh"

package noc_pkg;

	// top two bits of every flit
	typedef enum logic [1:0] {
		TAIL_FLIT = 2'b00,
		HEAD_FLIT = 2'b01,
		BODY_FLIT = 2'b10,
		HEADER    = 2'b11 // single-flit packet
	} flit_kind_t;

	// values 0 to 2 double as network port numbers
	typedef enum logic [1:0] {
		ANTI_CLOCKWISE = 2'd0,
		CLOCKWISE      = 2'd1,
		ACROSS         = 2'd2,
		STOP           = 2'd3 // eject to the processor
	} dir_t;

	typedef struct packed {
		logic [`NOC_NODE_W-1:0]         dest;
		logic [`NOC_NODE_W-1:0]         src;
		logic [`NOC_HEAD_PAYLOAD_W-1:0] payload;
	} head_fields_t;

	typedef struct packed {
		logic [`NOC_BODY_PAYLOAD_W-1:0] payload;
	} data_fields_t;

	// head and header flits carry addresses, body and tail flits carry only data
	typedef union packed {
		head_fields_t head;
		data_fields_t data;
	} flit_body_u;

	typedef struct packed {
		flit_kind_t            kind;
		logic [`NOC_VC_W-1:0]  vc; // vc index at the sending node
		flit_body_u            body;
	} flit_t;

	typedef struct packed {
		logic  valid;
		flit_t flit;
	} link_t;

	// per-vc flow control toward the upstream node
	typedef struct packed {
		logic [`NOC_NUM_VCS-1:0] ready; // vc unreserved, may take a head
		logic [`NOC_NUM_VCS-1:0] full;  // vc holds a full buffer of flits
	} port_status_t;

endpackage

`default_nettype wire

//--- logic/rr_arbiter.sv
// round-robin arbiter for N requesters with a rotating priority pointer
`default_nettype none

module rr_arbiter #(
	parameter int N = 2
) (
	input  logic         clk,
	input  logic         reset,
	input  logic [N-1:0] req,
	input  logic         advance, // move priority past this cycle's winner
	output logic [N-1:0] grant    // one-hot, combinational
);
	localparam int PTR_W = (N > 1) ? $clog2(N) : 1;

	logic [PTR_W-1:0] ptr;     // highest priority requester
	logic [PTR_W-1:0] win_idx; // index of the granted requester

	// first requester at or after the pointer wins
	always_comb
	begin
		int idx;
		logic found;
		grant = '0;
		win_idx = ptr;
		found = 1'b0;
		for (int i = 0; i < N; i++)
		begin
			idx = (int'(ptr) + i) % N; // wrap around the ring of requesters
			if (!found && req[idx])
			begin
				grant[idx] = 1'b1;
				win_idx = PTR_W'(idx);
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
			ptr <= '0;
		else if (advance && |req)
			ptr <= (win_idx == PTR_W'(N - 1)) ? '0 : win_idx + 1'b1; // winner drops to last
	end

endmodule

`default_nettype wire

//--- logic/vc_fifo.sv
// virtual channel buffer, a strict FIFO of flits with full and empty flags
`default_nettype none
`include "noc_params.svh"

module vc_fifo import noc_pkg::*; (
	input  logic  clk,
	input  logic  reset,
	input  logic  push,
	input  flit_t push_flit,
	input  logic  pop,
	output flit_t front, // oldest flit, valid while not empty
	output logic  empty,
	output logic  full
);
	localparam int DEPTH = `NOC_VC_DEPTH;
	localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
	localparam int CNT_W = $clog2(DEPTH + 1);

	flit_t            mem [DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic [CNT_W-1:0] count; // flits held
	logic             do_push;
	logic             do_pop;

	function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
		return (ptr == PTR_W'(DEPTH - 1)) ? '0 : ptr + 1'b1;
	endfunction

	assign do_pop = pop && !empty;
	assign do_push = push && (!full || do_pop); // a full buffer still takes a push on a pop
	assign empty = (count == '0);
	assign full = (count == CNT_W'(DEPTH));
	assign front = mem[rd_ptr];

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			rd_ptr <= '0;
			wr_ptr <= '0;
			count <= '0;
		end
		else
		begin
			if (do_push)
				wr_ptr <= next_ptr(wr_ptr);
			if (do_pop)
				rd_ptr <= next_ptr(rd_ptr);
			if (do_push && !do_pop)
				count <= count + 1'b1;
			else if (do_pop && !do_push)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk)
	begin
		if (do_push)
			mem[wr_ptr] <= push_flit;
	end

endmodule

`default_nettype wire

//--- logic/spidergon_route.sv
// spidergon routing, picks the outgoing direction from the destination node id
`default_nettype none
`include "noc_params.svh"

module spidergon_route import noc_pkg::*; #(
	parameter int NODE_ID = 0
) (
	input  logic [`NOC_NODE_W-1:0] dest,
	output dir_t                   route
);
	localparam int NUM_NODES = `NOC_NUM_NODES;

	int rel; // hops clockwise from this node to dest

	always_comb
	begin
		rel = (int'(dest) - NODE_ID + NUM_NODES) % NUM_NODES;
		if (rel == 0)
			route = STOP; // arrived
		else if (rel <= NUM_NODES / 4)
			route = CLOCKWISE;
		else if (rel >= 3 * NUM_NODES / 4)
			route = ANTI_CLOCKWISE;
		else
			route = ACROSS; // far half of the ring, jump to the opposite node
	end

endmodule

`default_nettype wire

//--- logic/input_port.sv
// input port of a spidergon node, steers link flits into virtual channels and tracks them
`default_nettype none
`include "noc_params.svh"

module input_port import noc_pkg::*; #(
	parameter int NODE_ID = 0
) (
	input  logic                    clk,
	input  logic                    reset,
	input  link_t                   in_link,
	output port_status_t            status,
	output flit_t [`NOC_NUM_VCS-1:0] vc_head,     // front flit with local vc index
	output logic [`NOC_NUM_VCS-1:0] vc_req,      // vc holds a flit
	output logic [`NOC_NUM_VCS-1:0] vc_reserved,
	output dir_t [`NOC_NUM_VCS-1:0] vc_route,
	input  logic [`NOC_NUM_VCS-1:0] vc_grant     // pop the front flit at this edge
);
	localparam int NUM_VC = `NOC_NUM_VCS;

	// vc allocation table
	logic [NUM_VC-1:0]                reserved;
	logic [NUM_VC-1:0]                open;  // body and tail flits still to come
	logic [NUM_VC-1:0][`NOC_VC_W-1:0] up_vc; // vc index used by the upstream node
	dir_t [NUM_VC-1:0]                route_q;

	logic              is_head;
	logic              is_body;
	logic              is_tail;
	dir_t              head_route;
	logic [NUM_VC-1:0] free_grant; // free vc picked for an incoming head
	logic [NUM_VC-1:0] head_take;
	logic [NUM_VC-1:0] body_take;
	logic [NUM_VC-1:0] release_vc;
	logic [NUM_VC-1:0] empty;
	logic [NUM_VC-1:0] full;
	flit_t [NUM_VC-1:0] front;

	assign is_head = in_link.valid &&
		(in_link.flit.kind == HEAD_FLIT || in_link.flit.kind == HEADER);
	assign is_body = in_link.valid &&
		(in_link.flit.kind == BODY_FLIT || in_link.flit.kind == TAIL_FLIT);
	assign is_tail = (in_link.flit.kind == TAIL_FLIT);

	// picks among unreserved vcs
	rr_arbiter #(.N(NUM_VC)) u_vc_alloc (
		.clk(clk),
		.reset(reset),
		.req(~reserved),
		.advance(is_head),
		.grant(free_grant)
	);

	// route is only stored when a head is accepted
	spidergon_route #(.NODE_ID(NODE_ID)) u_route (
		.dest(in_link.flit.body.head.dest),
		.route(head_route)
	);

	always_comb
	begin
		for (int i = 0; i < NUM_VC; i++)
		begin
			head_take[i] = is_head && free_grant[i];
			body_take[i] = is_body && open[i] && (up_vc[i] == in_link.flit.vc); // follow the head
			release_vc[i] = vc_grant[i] &&
				(front[i].kind == TAIL_FLIT || front[i].kind == HEADER); // last flit leaves
			vc_head[i] = front[i];
			vc_head[i].vc = `NOC_VC_W'(i); // downstream sees our vc index
		end
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			reserved <= '0;
			open <= '0;
		end
		else
		begin
			for (int i = 0; i < NUM_VC; i++)
			begin
				if (head_take[i])
				begin
					reserved[i] <= 1'b1;
					open[i] <= (in_link.flit.kind == HEAD_FLIT); // a header has nothing behind it
				end
				else
				begin
					if (release_vc[i])
						reserved[i] <= 1'b0;
					if (body_take[i] && is_tail)
						open[i] <= 1'b0; // packet fully received
				end
			end
		end
	end

	// table payload, meaningful only while reserved
	always_ff @(posedge clk)
	begin
		for (int i = 0; i < NUM_VC; i++)
		begin
			if (head_take[i])
			begin
				up_vc[i] <= in_link.flit.vc;
				route_q[i] <= head_route;
			end
		end
	end

	for (genvar v = 0; v < NUM_VC; v++)
	begin : g_vc
		vc_fifo u_fifo (
			.clk(clk),
			.reset(reset),
			.push(head_take[v] || body_take[v]),
			.push_flit(in_link.flit), // vc field rewritten on the way out
			.pop(vc_grant[v]),
			.front(front[v]),
			.empty(empty[v]),
			.full(full[v])
		);
	end

	assign vc_req = ~empty;
	assign vc_reserved = reserved;
	assign vc_route = route_q;
	assign status = '{ready: ~reserved, full: full};

endmodule

`default_nettype wire

//--- logic/switch_allocator.sv
// switch allocator, round robin per output with a wormhole lock on the granted vc
`default_nettype none
`include "noc_params.svh"

module switch_allocator import noc_pkg::*; (
	input  logic                                   clk,
	input  logic                                   reset,
	input  logic [`NOC_NUM_DIRS*`NOC_NUM_VCS-1:0]  vc_req,
	input  logic [`NOC_NUM_DIRS*`NOC_NUM_VCS-1:0]  vc_reserved,
	input  dir_t [`NOC_NUM_DIRS*`NOC_NUM_VCS-1:0]  vc_route,
	input  logic [`NOC_NUM_DIRS-1:0]               out_stall,
	output logic [`NOC_NUM_DIRS*`NOC_NUM_VCS-1:0]  vc_grant
);
	localparam int NUM_VC = `NOC_NUM_DIRS * `NOC_NUM_VCS;
	localparam int NUM_OUT = `NOC_NUM_DIRS + 1; // network links plus the cpu
	localparam int IDX_W = $clog2(NUM_VC);

	logic [NUM_VC-1:0] out_grant [NUM_OUT];

	for (genvar o = 0; o < NUM_OUT; o++)
	begin : g_out
		logic              locked;
		logic [IDX_W-1:0]  holder;      // vc owning this output
		logic              lock_active; // holder still has its packet
		logic              stall;
		logic [NUM_VC-1:0] routed_req;
		logic [NUM_VC-1:0] arb_req;
		logic [NUM_VC-1:0] arb_grant;
		logic [IDX_W-1:0]  arb_idx;

		if (o < `NOC_NUM_DIRS)
		begin : g_link
			assign stall = out_stall[o];
		end
		else
		begin : g_cpu
			assign stall = 1'b0; // ejection never stalls
		end

		// lock ends as soon as the holder drops its reservation
		assign lock_active = locked && vc_reserved[holder];
		assign arb_req = lock_active ? '0 : routed_req;

		always_comb
		begin
			arb_idx = '0;
			for (int i = 0; i < NUM_VC; i++)
			begin
				routed_req[i] = vc_req[i] && (vc_route[i] == dir_t'(o));
				if (arb_grant[i])
					arb_idx = IDX_W'(i);
			end
		end

		rr_arbiter #(.N(NUM_VC)) u_arb (
			.clk(clk),
			.reset(reset),
			.req(arb_req),
			.advance(!stall), // no rotation on a stalled output
			.grant(arb_grant)
		);

		assign out_grant[o] = stall ? '0 :
			lock_active ? (routed_req & (NUM_VC'(1) << holder)) : arb_grant;

		always_ff @(posedge clk)
		begin
			if (reset)
				locked <= 1'b0;
			else if (!lock_active)
				locked <= |out_grant[o]; // new packet takes the output
		end

		always_ff @(posedge clk)
		begin
			if (!lock_active && |out_grant[o])
				holder <= arb_idx;
		end
	end

	// each vc routes to one output, so at most one grant per vc
	always_comb
	begin
		vc_grant = '0;
		for (int o = 0; o < NUM_OUT; o++)
			vc_grant = vc_grant | out_grant[o];
	end

endmodule

`default_nettype wire

//--- logic/spidergon_node.sv
// spidergon node with three input ports, switch allocation, crossbar and output registers
`default_nettype none
`include "noc_params.svh"

module spidergon_node import noc_pkg::*; #(
	parameter int NODE_ID = 0
) (
	input  logic                                clk,
	input  logic                                reset,
	input  link_t [`NOC_NUM_DIRS-1:0]           in_link,
	output port_status_t [`NOC_NUM_DIRS-1:0]    in_status,
	output link_t [`NOC_NUM_DIRS-1:0]           out_link,
	input  logic [`NOC_NUM_DIRS-1:0]            out_stall,
	output link_t                               to_cpu
);
	localparam int NUM_DIRS = `NOC_NUM_DIRS;
	localparam int NUM_VCS = `NOC_NUM_VCS;
	localparam int NUM_VC = NUM_DIRS * NUM_VCS; // vc i sits in port i / NUM_VCS

	flit_t [NUM_VC-1:0] vc_head;
	logic [NUM_VC-1:0]  vc_req;
	logic [NUM_VC-1:0]  vc_reserved;
	dir_t [NUM_VC-1:0]  vc_route;
	logic [NUM_VC-1:0]  vc_grant;

	for (genvar p = 0; p < NUM_DIRS; p++)
	begin : g_port
		input_port #(.NODE_ID(NODE_ID)) u_in (
			.clk(clk),
			.reset(reset),
			.in_link(in_link[p]),
			.status(in_status[p]),
			.vc_head(vc_head[p*NUM_VCS +: NUM_VCS]),
			.vc_req(vc_req[p*NUM_VCS +: NUM_VCS]),
			.vc_reserved(vc_reserved[p*NUM_VCS +: NUM_VCS]),
			.vc_route(vc_route[p*NUM_VCS +: NUM_VCS]),
			.vc_grant(vc_grant[p*NUM_VCS +: NUM_VCS])
		);
	end

	switch_allocator u_sa (
		.clk(clk),
		.reset(reset),
		.vc_req(vc_req),
		.vc_reserved(vc_reserved),
		.vc_route(vc_route),
		.out_stall(out_stall),
		.vc_grant(vc_grant)
	);

	// crossbar, output NUM_DIRS is the cpu ejection port
	for (genvar o = 0; o <= NUM_DIRS; o++)
	begin : g_xbar
		logic  sel_valid;
		flit_t sel_flit;
		logic  q_valid;
		flit_t q_flit;

		always_comb
		begin
			sel_valid = 1'b0;
			sel_flit = vc_head[0];
			for (int i = 0; i < NUM_VC; i++)
			begin
				if (vc_grant[i] && vc_route[i] == dir_t'(o))
				begin
					sel_valid = 1'b1;
					sel_flit = vc_head[i];
				end
			end
		end

		always_ff @(posedge clk)
		begin
			if (reset)
				q_valid <= 1'b0;
			else
				q_valid <= sel_valid; // low after a stalled or idle edge
		end

		always_ff @(posedge clk)
		begin
			if (sel_valid)
				q_flit <= sel_flit;
		end

		if (o < NUM_DIRS)
		begin : g_link
			assign out_link[o] = '{valid: q_valid, flit: q_flit};
		end
		else
		begin : g_cpu
			assign to_cpu = '{valid: q_valid, flit: q_flit};
		end
	end

endmodule

`default_nettype wire

//--- testbench/node_properties.sv
// concurrent checks on a spidergon node for reset state, stall response and packet contiguity
`default_nettype none
`include "noc_params.svh"

module node_properties import noc_pkg::*; (
	input logic                             clk,
	input logic                             reset,
	input port_status_t [`NOC_NUM_DIRS-1:0] in_status,
	input link_t [`NOC_NUM_DIRS-1:0]        out_link,
	input logic [`NOC_NUM_DIRS-1:0]         out_stall,
	input link_t                            to_cpu
);
	int unsigned fail_count = 0; // read by the testbench at the end

	link_t lnk [4];
	logic [3:0] in_pkt; // between a head and its tail on each output

	assign lnk[0] = out_link[0];
	assign lnk[1] = out_link[1];
	assign lnk[2] = out_link[2];
	assign lnk[3] = to_cpu;

	always_ff @(posedge clk)
	begin
		for (int o = 0; o < 4; o++)
		begin
			if (reset)
				in_pkt[o] <= 1'b0;
			else if (lnk[o].valid && lnk[o].flit.kind == HEAD_FLIT)
				in_pkt[o] <= 1'b1;
			else if (lnk[o].valid && lnk[o].flit.kind == TAIL_FLIT)
				in_pkt[o] <= 1'b0; // packet closed
		end
	end

	// idle outputs and free unfilled vcs right after reset
	reset_state: assert property (@(posedge clk) reset |=>
		(!out_link[0].valid && !out_link[1].valid && !out_link[2].valid && !to_cpu.valid &&
		in_status[0].ready == '1 && in_status[1].ready == '1 && in_status[2].ready == '1 &&
		in_status[0].full == '0 && in_status[1].full == '0 && in_status[2].full == '0))
	else
	begin
		fail_count++;
		$error("outputs or port status not idle after reset");
	end

	for (genvar d = 0; d < `NOC_NUM_DIRS; d++)
	begin : g_stall
		stall_idle: assert property (@(posedge clk) disable iff (reset)
			out_stall[d] |=> !out_link[d].valid)
		else
		begin
			fail_count++;
			$error("output %0d sent a flit after a stalled edge", d);
		end
	end

	for (genvar o = 0; o < 4; o++)
	begin : g_order
		no_interleave: assert property (@(posedge clk) disable iff (reset)
			(lnk[o].valid && in_pkt[o]) |->
			(lnk[o].flit.kind == BODY_FLIT || lnk[o].flit.kind == TAIL_FLIT))
		else
		begin
			fail_count++;
			$error("new packet started inside another on output %0d", o);
		end
	end

endmodule

bind spidergon_node node_properties u_props (
	.clk(clk),
	.reset(reset),
	.in_status(in_status),
	.out_link(out_link),
	.out_stall(out_stall),
	.to_cpu(to_cpu)
);

`default_nettype wire

//--- testbench/tb_spidergon_node.sv
// testbench for one spidergon node, random packet traffic checked against per-output scoreboards
`default_nettype none
`include "noc_params.svh"

module tb_spidergon_node import noc_pkg::*;;
	localparam int CYCLE_LIMIT = 4000; // about 60 packets of up to four flits, with stalls
	localparam int DRAIN_LIMIT = 100;  // twelve buffered flits at most, even all on one output
	localparam int MAX_TAGS = 64;

	logic clk = 1'b0;
	logic reset;
	link_t [`NOC_NUM_DIRS-1:0] in_link;
	port_status_t [`NOC_NUM_DIRS-1:0] in_status;
	link_t [`NOC_NUM_DIRS-1:0] out_link;
	logic [`NOC_NUM_DIRS-1:0] out_stall;
	link_t to_cpu;
	link_t mon [4]; // outputs 0 to 2 are links, 3 is the cpu

	flit_t exp_flits [MAX_TAGS][$]; // expected flits of each packet, vc field zeroed
	int pending [4][$];             // packets whose head has not yet left each output
	int cur_tag [4];                // packet now passing each output
	logic [`NOC_VC_W-1:0] cur_vc [4];
	logic [15:0] lfsr = 16'd63;
	int next_tag = 0;
	int ports_done = 0;
	int mismatch_count = 0;
	int other_count = 0;
	int cycles = 0;
	int total;

	spidergon_node #(.NODE_ID(0)) u_dut (
		.clk(clk),
		.reset(reset),
		.in_link(in_link),
		.in_status(in_status),
		.out_link(out_link),
		.out_stall(out_stall),
		.to_cpu(to_cpu)
	);

	assign mon[0] = out_link[0];
	assign mon[1] = out_link[1];
	assign mon[2] = out_link[2];
	assign mon[3] = to_cpu;

	always #5 clk = ~clk;

	// galois lfsr, taps 16,14,13,11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
	endfunction

	task automatic take_bits(input int n, output int v);
		v = 0;
		for (int i = 0; i < n; i++)
		begin
			v = (v << 1) | int'(lfsr[0]);
			lfsr = lfsr_next(lfsr); // one step per bit
		end
	endtask

	// ring distance decides the output, 3 means eject to the cpu
	function automatic int expected_output(input int dest);
		int rel;
		rel = dest % 8;
		if (rel == 0)
			return 3;
		if (rel <= 2)
			return 1; // clockwise
		if (rel >= 6)
			return 0; // anticlockwise
		return 2; // across
	endfunction

	function automatic int outstanding_flits();
		int n;
		n = 0;
		for (int t = 0; t < MAX_TAGS; t++)
			n += exp_flits[t].size();
		return n;
	endfunction

	// builds a packet and files its flits in the scoreboard before anything is sent
	task automatic record_packet(input int dest, input int len, input int up_vc,
		output flit_t pkt [4]);
		int tag;
		int src;
		int pay;
		int out;
		flit_t e;
		tag = next_tag;
		next_tag++;
		out = expected_output(dest);
		take_bits(3, src);
		for (int i = 0; i < len; i++)
		begin
			pkt[i].vc = `NOC_VC_W'(up_vc);
			if (i == 0)
			begin
				pkt[i].kind = (len == 1) ? HEADER : HEAD_FLIT;
				pkt[i].body.head.dest = `NOC_NODE_W'(dest);
				pkt[i].body.head.src = `NOC_NODE_W'(src);
				pkt[i].body.head.payload = `NOC_HEAD_PAYLOAD_W'(tag); // unique tag per packet
			end
			else
			begin
				pkt[i].kind = (i == len - 1) ? TAIL_FLIT : BODY_FLIT;
				take_bits(15, pay);
				pkt[i].body.data.payload = `NOC_BODY_PAYLOAD_W'(pay);
			end
			e = pkt[i];
			e.vc = '0;
			exp_flits[tag].push_back(e);
		end
		pending[out].push_back(tag);
	endtask

	// one flit every other cycle, so status at the negedge already shows the last flit
	task automatic send_flit(input int p, input flit_t f, input bit head);
		do
			@(negedge clk);
		while (head ? (in_status[p].ready == '0) : (in_status[p].full != '0));
		@(posedge clk);
		in_link[p] <= '{valid: 1'b1, flit: f};
		@(posedge clk);
		in_link[p].valid <= 1'b0;
	endtask

	task automatic send_packet(input int p, input int dest, input int len, input int up_vc);
		flit_t pkt [4];
		record_packet(dest, len, up_vc, pkt);
		for (int i = 0; i < len; i++)
			send_flit(p, pkt[i], i == 0);
	endtask

	task automatic port_traffic(input int p);
		int dest;
		int len;
		for (int k = 0; k < 16; k++)
		begin
			take_bits(3, dest);
			take_bits(2, len);
			send_packet(p, dest, len + 1, k % 2); // alternate upstream vc
		end
		ports_done++;
	endtask

	// each output stalls on about a quarter of the edges
	task automatic stall_pattern();
		int b;
		logic [`NOC_NUM_DIRS-1:0] s;
		while (ports_done < 3)
		begin
			@(posedge clk);
			for (int d = 0; d < `NOC_NUM_DIRS; d++)
			begin
				take_bits(2, b);
				s[d] = (b == 3);
			end
			out_stall <= s;
		end
		@(posedge clk);
		out_stall <= '0;
	endtask

	// outputs are sampled at the negedge where they are stable
	always @(negedge clk)
	begin
		flit_t f;
		flit_t got;
		int idx;
		int tag;
		for (int o = 0; o < 4; o++)
		begin
			if (!reset && mon[o].valid)
			begin
				f = mon[o].flit;
				got = f;
				got.vc = '0;
				if (f.kind == HEAD_FLIT || f.kind == HEADER)
				begin
					tag = int'(f.body.head.payload);
					idx = -1;
					for (int i = 0; i < pending[o].size(); i++)
						if (pending[o][i] == tag)
							idx = i;
					assert (idx >= 0)
					else
					begin
						$display("packet %0d left by output %0d, which is not its route", tag, o);
						other_count++;
					end
					if (idx >= 0)
						pending[o].delete(idx);
					cur_tag[o] = (idx >= 0) ? tag : -1;
					cur_vc[o] = f.vc;
				end
				else
				begin
					assert (f.vc == cur_vc[o]) // whole packet keeps one local vc
					else
					begin
						$display("Mismatch at %0t: out[%0d].flit.vc expected %h got %h",
							$time, o, cur_vc[o], f.vc);
						mismatch_count++;
					end
				end
				if (cur_tag[o] >= 0 && exp_flits[cur_tag[o]].size() > 0)
				begin
					assert (got == exp_flits[cur_tag[o]][0])
					else
					begin
						$display("Mismatch at %0t: out[%0d].flit expected %h got %h",
							$time, o, exp_flits[cur_tag[o]][0], got);
						mismatch_count++;
					end
					void'(exp_flits[cur_tag[o]].pop_front());
				end
				else
				begin
					$display("a flit left output %0d with no packet expected there", o);
					other_count++;
				end
			end
		end
	end

	always @(posedge clk)
	begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT)
		begin
			$display("timeout, the run did not finish within %0d cycles", CYCLE_LIMIT);
			$display("=== FAIL ===");
			$finish;
		end
	end

	initial
	begin
		flit_t pkt [4];
		reset = 1'b1;
		in_link = '0;
		out_stall = '0;
		for (int o = 0; o < 4; o++)
		begin
			cur_tag[o] = -1;
			cur_vc[o] = '0;
		end
		repeat (5) @(posedge clk);
		reset <= 1'b0;

		// every destination once, as single-flit packets
		for (int d = 0; d < 8; d++)
			send_packet(d % 3, d, 1, 0);

		// vc status with all links stalled, head body tail toward node 1
		@(posedge clk);
		out_stall <= '1;
		record_packet(1, 3, 0, pkt);
		send_flit(0, pkt[0], 1'b1);
		@(negedge clk);
		assert ($countones(in_status[0].ready) == 1)
		else
		begin
			$display("no ready bit fell after the head was accepted");
			other_count++;
		end
		send_flit(0, pkt[1], 1'b0);
		@(negedge clk);
		assert (in_status[0].full != '0)
		else
		begin
			$display("two queued flits did not raise a full bit");
			other_count++;
		end
		@(posedge clk);
		out_stall <= '0;
		send_flit(0, pkt[2], 1'b0);
		do
			@(negedge clk);
		while (in_status[0].ready != '1); // vc freed once the tail is gone

		// three ports at once with random stalls
		fork
			port_traffic(0);
			port_traffic(1);
			port_traffic(2);
			stall_pattern();
		join

		// stalls are off, the buffered flits get a bounded time to leave
		for (int i = 0; i < DRAIN_LIMIT && outstanding_flits() > 0; i++)
			@(negedge clk);
		repeat (5) @(posedge clk);
		assert (outstanding_flits() == 0)
		else
		begin
			$display("flits were left in the scoreboard after the drain");
			other_count++;
		end

		total = mismatch_count + other_count + int'(u_dut.u_props.fail_count);
		$display("errors: %0d mismatches, %0d other, %0d assertion failures",
			mismatch_count, other_count, u_dut.u_props.fail_count);
		if (total == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+logic
logic/noc_pkg.sv
logic/rr_arbiter.sv
logic/vc_fifo.sv
logic/spidergon_route.sv
logic/input_port.sv
logic/switch_allocator.sv
logic/spidergon_node.sv
testbench/node_properties.sv
testbench/tb_spidergon_node.sv

//--- run.sh
#!/bin/sh
# build and run the spidergon node testbench with verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f filelist.f \
	--top-module tb_spidergon_node -o sim_tb
if [ $? -ne 0 ]; then
	echo "compile failed"
	exit 1
fi

./obj_dir/sim_tb +verilator+error+limit+1000 > sim.log 2>&1
run_status=$?
cat sim.log
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "=== FAIL ===" sim.log; then
	exit 1
fi
exit 0
